// ==== hdl/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath widths
`define EX_DATA_W 32
`define EX_REG_W 5
`define EX_IMM_W 16

// iterations of the restoring divider, one quotient bit each
`define EX_DIV_STEPS 32

`endif

// ==== hdl/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_t;

    typedef enum logic [3:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_mult,
        cls_multu,
        cls_div,
        cls_divu,
        cls_mfhi,
        cls_mflo,
        cls_mthi,
        cls_mtlo
    } ex_class_t;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,
        src1_pc
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rt,
        src2_imm_sext,
        src2_imm_zext,
        src2_eight
    } src2_sel_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    typedef enum logic [1:0] {
        exc_none,
        exc_overflow,
        exc_adel,
        exc_ades
    } ex_code_t;

    // decoded instruction from decode
    typedef struct packed {
        ex_class_t              op_class;
        alu_op_t                alu_op;
        src1_sel_t              src1_sel;
        src2_sel_t              src2_sel;
        mem_size_t              mem_size;
        logic                   trap_ovf;
        logic                   gr_we;
        logic [`EX_REG_W-1:0]   dest;
        logic [`EX_IMM_W-1:0]   imm;
        logic [`EX_DATA_W-1:0]  rs_value;
        logic [`EX_DATA_W-1:0]  rt_value;
        logic [`EX_DATA_W-1:0]  pc;
    } ex_in_t;

    // bundle for the memory stage
    typedef struct packed {
        logic [`EX_DATA_W-1:0]  pc;
        logic [`EX_DATA_W-1:0]  result;
        logic [`EX_REG_W-1:0]   dest;
        logic                   gr_we;
        logic                   res_from_mem;
        ex_code_t               ex_code;
    } ex_out_t;

    typedef struct packed {
        logic [3:0]             wen;
        logic [`EX_DATA_W-1:0]  addr;
        logic [`EX_DATA_W-1:0]  wdata;
    } dsram_req_t;

endpackage

// ==== hdl/ex_alu.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_alu (
    input  ex_pkg::alu_op_t        op,
    input  ex_pkg::src1_sel_t      src1_sel,
    input  ex_pkg::src2_sel_t      src2_sel,
    input  logic [`EX_DATA_W-1:0]  rs_value,
    input  logic [`EX_DATA_W-1:0]  rt_value,
    input  logic [`EX_DATA_W-1:0]  pc,
    input  logic [`EX_IMM_W-1:0]   imm,
    input  logic                   trap_ovf,
    output logic [`EX_DATA_W-1:0]  result,
    output logic                   overflow
);

    localparam int W    = `EX_DATA_W;
    localparam int SH_W = $clog2(`EX_DATA_W);

    logic [W-1:0] src1;
    logic [W-1:0] src2;
    logic [W-1:0] add_sum;
    logic [W-1:0] sub_diff;
    logic         ovf_add;
    logic         ovf_sub;

    always_comb begin
        case (src1_sel)
            ex_pkg::src1_sa: src1 = {{(W-5){1'b0}}, imm[10:6]};
            ex_pkg::src1_pc: src1 = pc;
            default:         src1 = rs_value;
        endcase
        case (src2_sel)
            ex_pkg::src2_imm_sext: src2 = {{(W-`EX_IMM_W){imm[`EX_IMM_W-1]}}, imm};
            ex_pkg::src2_imm_zext: src2 = {{(W-`EX_IMM_W){1'b0}}, imm};
            ex_pkg::src2_eight:    src2 = W'(8);
            default:               src2 = rt_value;
        endcase
    end

    assign add_sum  = src1 + src2;
    assign sub_diff = src1 - src2;

    // sign of the result disagrees with what the operands allow
    assign ovf_add = (src1[W-1] == src2[W-1]) && (add_sum[W-1] != src1[W-1]);
    assign ovf_sub = (src1[W-1] != src2[W-1]) && (sub_diff[W-1] != src1[W-1]);

    assign overflow = trap_ovf &&
                      (((op == ex_pkg::op_add) && ovf_add) ||
                       ((op == ex_pkg::op_sub) && ovf_sub));

    always_comb begin
        case (op)
            ex_pkg::op_add,
            ex_pkg::op_addu: result = add_sum;
            ex_pkg::op_sub,
            ex_pkg::op_subu: result = sub_diff;
            ex_pkg::op_slt:  result = {{(W-1){1'b0}}, $signed(src1) < $signed(src2)};
            ex_pkg::op_sltu: result = {{(W-1){1'b0}}, src1 < src2};
            ex_pkg::op_and:  result = src1 & src2;
            ex_pkg::op_or:   result = src1 | src2;
            ex_pkg::op_xor:  result = src1 ^ src2;
            ex_pkg::op_nor:  result = ~(src1 | src2);
            ex_pkg::op_sll:  result = src2 << src1[SH_W-1:0];
            ex_pkg::op_srl:  result = src2 >> src1[SH_W-1:0];
            ex_pkg::op_sra:  result = $signed(src2) >>> src1[SH_W-1:0];
            ex_pkg::op_lui:  result = {src2[15:0], 16'b0};
            default:         result = '0;
        endcase
    end

endmodule

// ==== hdl/ex_mem_access.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_mem_access (
    input  ex_pkg::ex_class_t      op_class,
    input  ex_pkg::mem_size_t      size,
    input  logic [`EX_DATA_W-1:0]  addr,
    input  logic [`EX_DATA_W-1:0]  rt_value,
    input  logic                   commit,
    input  logic                   overflow,
    output ex_pkg::dsram_req_t     dsram,
    output logic                   align_err
);

    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic [3:0] lane_en;

    assign is_load  = (op_class == ex_pkg::cls_load);
    assign is_store = (op_class == ex_pkg::cls_store);

    always_comb begin
        case (size)
            ex_pkg::size_byte: begin
                misaligned  = 1'b0;
                lane_en     = 4'b0001 << addr[1:0];
                dsram.wdata = {4{rt_value[7:0]}};
            end
            ex_pkg::size_half: begin
                misaligned  = addr[0];
                lane_en     = addr[1] ? 4'b1100 : 4'b0011;
                dsram.wdata = {2{rt_value[15:0]}};
            end
            default: begin
                misaligned  = |addr[1:0];
                lane_en     = 4'b1111;
                dsram.wdata = rt_value;
            end
        endcase
    end

    assign align_err  = misaligned && (is_load || is_store);
    assign dsram.addr = addr;
    // write only as the store leaves, and only if it is clean
    assign dsram.wen  = (commit && is_store && !align_err && !overflow) ? lane_en : 4'b0000;

endmodule

// ==== hdl/ex_divider.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_divider (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   div_start,
    input  logic                   is_signed,
    input  logic [`EX_DATA_W-1:0]  dividend,
    input  logic [`EX_DATA_W-1:0]  divisor,
    output logic                   div_done,
    output logic [`EX_DATA_W-1:0]  quotient,
    output logic [`EX_DATA_W-1:0]  remainder
);

    localparam int W     = `EX_DATA_W;
    localparam int CNT_W = $clog2(`EX_DIV_STEPS);

    logic             busy_q;
    logic [CNT_W-1:0] step_q;
    logic [W-1:0]     rem_q;
    logic [W-1:0]     quo_q;
    logic [W-1:0]     dvsr_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic [W-1:0]     dividend_mag;
    logic [W-1:0]     divisor_mag;
    logic [W:0]       shifted;
    logic [W:0]       trial;

    assign dividend_mag = (is_signed && dividend[W-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[W-1]) ? -divisor : divisor;

    // bring in the next dividend bit and try a subtract
    assign shifted = {rem_q, quo_q[W-1]};
    assign trial   = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            step_q   <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == CNT_W'(`EX_DIV_STEPS - 1)) begin
                    busy_q   <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_q     <= '0;
            quo_q     <= dividend_mag;
            dvsr_q    <= divisor_mag;
            neg_quo_q <= is_signed && (dividend[W-1] ^ divisor[W-1]);
            neg_rem_q <= is_signed && dividend[W-1];
        end else if (busy_q) begin
            if (!trial[W]) begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // truncate toward zero, remainder follows the dividend
    assign quotient  = neg_quo_q ? -quo_q : quo_q;
    assign remainder = neg_rem_q ? -rem_q : rem_q;

endmodule

// ==== hdl/ex_hilo.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_hilo (
    input  logic                   clk,
    input  logic                   reset,
    input  ex_pkg::ex_class_t      op_class,
    input  logic                   commit,
    input  logic                   div_done,
    input  logic [`EX_DATA_W-1:0]  rs_value,
    input  logic [`EX_DATA_W-1:0]  rt_value,
    input  logic [`EX_DATA_W-1:0]  quotient,
    input  logic [`EX_DATA_W-1:0]  remainder,
    output logic [`EX_DATA_W-1:0]  hi,
    output logic [`EX_DATA_W-1:0]  lo
);

    localparam int W = `EX_DATA_W;

    logic [2*W-1:0] prod_s;
    logic [2*W-1:0] prod_u;

    assign prod_s = $signed({{W{rs_value[W-1]}}, rs_value}) *
                    $signed({{W{rt_value[W-1]}}, rt_value});
    assign prod_u = {{W{1'b0}}, rs_value} * {{W{1'b0}}, rt_value};

    // divide finishes while the stage waits, so it never meets a commit
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            hi <= remainder;
            lo <= quotient;
        end else if (commit) begin
            case (op_class)
                ex_pkg::cls_mult:  {hi, lo} <= prod_s;
                ex_pkg::cls_multu: {hi, lo} <= prod_u;
                ex_pkg::cls_mthi:  hi <= rs_value;
                ex_pkg::cls_mtlo:  lo <= rs_value;
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/ex_stage_ctrl.sv ====
`timescale 1ns/100ps

module ex_stage_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic              out_allowin,
    input  ex_pkg::ex_class_t op_class,
    input  logic              div_done,
    output logic              in_allowin,
    output logic              load_en,
    output logic              out_valid,
    output logic              commit,
    output logic              div_start
);

    typedef enum logic [1:0] {
        st_empty,
        st_div_wait,
        st_ready
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   div_issue_q;
    logic   in_is_div;

    assign in_is_div = (op_class == ex_pkg::cls_div) || (op_class == ex_pkg::cls_divu);

    assign out_valid  = (state_q == st_ready);
    assign commit     = out_valid && out_allowin;
    // accept when empty or when the held one leaves this cycle
    assign in_allowin = (state_q == st_empty) || commit;
    assign load_en    = in_valid && in_allowin;
    assign div_start  = div_issue_q;

    always_comb begin
        state_d = state_q;
        if (load_en) begin
            state_d = in_is_div ? st_div_wait : st_ready;
        end else if (commit) begin
            state_d = st_empty;
        end else if ((state_q == st_div_wait) && div_done) begin
            state_d = st_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= st_empty;
            div_issue_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // one cycle after a divide is captured
            div_issue_q <= load_en && in_is_div;
        end
    end

endmodule

// ==== hdl/ex_stage_top.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_stage_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_allowin,
    input  ex_pkg::ex_in_t      in_bus,
    output logic                out_valid,
    input  logic                out_allowin,
    output ex_pkg::ex_out_t     out_bus,
    output ex_pkg::dsram_req_t  dsram
);

    ex_pkg::ex_in_t         stage_q;
    logic                   load_en;
    logic                   commit;
    logic                   div_start;
    logic                   div_done;
    logic [`EX_DATA_W-1:0]  alu_result;
    logic                   overflow;
    logic                   align_err;
    logic [`EX_DATA_W-1:0]  quotient;
    logic [`EX_DATA_W-1:0]  remainder;
    logic [`EX_DATA_W-1:0]  hi;
    logic [`EX_DATA_W-1:0]  lo;
    logic                   is_div;
    logic                   is_load;
    logic                   is_store;

    ex_stage_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .out_allowin (out_allowin),
        .op_class    (in_bus.op_class),
        .div_done    (div_done),
        .in_allowin  (in_allowin),
        .load_en     (load_en),
        .out_valid   (out_valid),
        .commit      (commit),
        .div_start   (div_start)
    );

    // stage register, held while the memory stage stalls
    always_ff @(posedge clk) begin
        if (load_en) begin
            stage_q <= in_bus;
        end
    end

    ex_alu u_alu (
        .op       (stage_q.alu_op),
        .src1_sel (stage_q.src1_sel),
        .src2_sel (stage_q.src2_sel),
        .rs_value (stage_q.rs_value),
        .rt_value (stage_q.rt_value),
        .pc       (stage_q.pc),
        .imm      (stage_q.imm),
        .trap_ovf (stage_q.trap_ovf),
        .result   (alu_result),
        .overflow (overflow)
    );

    ex_mem_access u_mem_access (
        .op_class  (stage_q.op_class),
        .size      (stage_q.mem_size),
        .addr      (alu_result),
        .rt_value  (stage_q.rt_value),
        .commit    (commit),
        .overflow  (overflow),
        .dsram     (dsram),
        .align_err (align_err)
    );

    assign is_div = (stage_q.op_class == ex_pkg::cls_div);

    ex_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .div_start (div_start),
        .is_signed (is_div),
        .dividend  (stage_q.rs_value),
        .divisor   (stage_q.rt_value),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    ex_hilo u_hilo (
        .clk       (clk),
        .reset     (reset),
        .op_class  (stage_q.op_class),
        .commit    (commit),
        .div_done  (div_done),
        .rs_value  (stage_q.rs_value),
        .rt_value  (stage_q.rt_value),
        .quotient  (quotient),
        .remainder (remainder),
        .hi        (hi),
        .lo        (lo)
    );

    assign is_load  = (stage_q.op_class == ex_pkg::cls_load);
    assign is_store = (stage_q.op_class == ex_pkg::cls_store);

    always_comb begin
        out_bus.pc           = stage_q.pc;
        out_bus.dest         = stage_q.dest;
        out_bus.gr_we        = stage_q.gr_we;
        out_bus.res_from_mem = is_load;
        case (stage_q.op_class)
            ex_pkg::cls_mfhi: out_bus.result = hi;
            ex_pkg::cls_mflo: out_bus.result = lo;
            default:          out_bus.result = alu_result;
        endcase
        // overflow wins over address errors
        if (overflow) begin
            out_bus.ex_code = ex_pkg::exc_overflow;
        end else if (align_err && is_load) begin
            out_bus.ex_code = ex_pkg::exc_adel;
        end else if (align_err && is_store) begin
            out_bus.ex_code = ex_pkg::exc_ades;
        end else begin
            out_bus.ex_code = ex_pkg::exc_none;
        end
    end

endmodule

// ==== sim/tb_ex_stage.sv ====
`timescale 1ns/100ps
`include "ex_config.svh"

module tb_ex_stage;

    localparam int MAX_VEC        = 64;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 400;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_allowin;
    ex_pkg::ex_in_t      in_bus;
    logic                out_valid;
    logic                out_allowin;
    ex_pkg::ex_out_t     out_bus;
    ex_pkg::dsram_req_t  dsram;

    ex_pkg::ex_in_t          vec_in [MAX_VEC];
    logic [`EX_DATA_W-1:0]   exp_result [MAX_VEC];
    logic [1:0]              exp_code [MAX_VEC];
    logic [3:0]              exp_wen [MAX_VEC];
    logic [`EX_DATA_W-1:0]   exp_wdata [MAX_VEC];
    int                      accept_cycle [MAX_VEC];
    int                      num_vec;
    int                      commit_idx;
    int                      cycle;

    ex_stage_top uut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_bus      (in_bus),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_bus     (out_bus),
        .dsram       (dsram)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial cycle = 0;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // classes that write a general register
    function automatic logic writes_gpr(input ex_pkg::ex_class_t cls);
        return (cls == ex_pkg::cls_alu) || (cls == ex_pkg::cls_load) ||
               (cls == ex_pkg::cls_mfhi) || (cls == ex_pkg::cls_mflo);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    task automatic load_vectors();
        int             fd;
        int             fields;
        string          line;
        logic [31:0]    f [15];
        ex_pkg::ex_in_t entry;
        fd = $fopen("sim/ex_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/ex_vectors.txt");
        end
        num_vec = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                             f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (fields == 15) begin
                if (num_vec == MAX_VEC) begin
                    abort_run("too many vectors in sim/ex_vectors.txt");
                end
                entry          = '0;
                entry.op_class = ex_pkg::ex_class_t'(f[0][3:0]);
                entry.alu_op   = ex_pkg::alu_op_t'(f[1][3:0]);
                entry.src1_sel = ex_pkg::src1_sel_t'(f[2][1:0]);
                entry.src2_sel = ex_pkg::src2_sel_t'(f[3][1:0]);
                entry.mem_size = ex_pkg::mem_size_t'(f[4][1:0]);
                entry.trap_ovf = f[5][0];
                entry.gr_we    = writes_gpr(entry.op_class);
                entry.dest     = f[6][`EX_REG_W-1:0];
                entry.rs_value = f[7];
                entry.rt_value = f[8];
                entry.imm      = f[9][`EX_IMM_W-1:0];
                entry.pc       = f[10];
                vec_in[num_vec]     = entry;
                exp_result[num_vec] = f[11];
                exp_code[num_vec]   = f[12][1:0];
                exp_wen[num_vec]    = f[13][3:0];
                exp_wdata[num_vec]  = f[14];
                num_vec++;
            end else if (line.len() > 1 && line.getc(0) != "#") begin
                abort_run($sformatf("malformed line in vector file: %s", line));
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            abort_run("no vectors found in sim/ex_vectors.txt");
        end
    endtask

    // compare one committing instruction with its vector
    task automatic check_commit(input int idx);
        ex_pkg::ex_in_t vin;
        logic           is_mem;
        vin    = vec_in[idx];
        is_mem = (vin.op_class == ex_pkg::cls_load) || (vin.op_class == ex_pkg::cls_store);
        assert (out_bus.pc == vin.pc) else
            report_mismatch($sformatf("vector %0d pc %h, expected %h", idx, out_bus.pc, vin.pc));
        assert (out_bus.result == exp_result[idx]) else
            report_mismatch($sformatf("vector %0d result %h, expected %h",
                                      idx, out_bus.result, exp_result[idx]));
        assert (out_bus.ex_code == exp_code[idx]) else
            report_mismatch($sformatf("vector %0d ex_code %0d, expected %0d",
                                      idx, out_bus.ex_code, exp_code[idx]));
        assert (out_bus.dest == vin.dest && out_bus.gr_we == vin.gr_we) else
            report_mismatch($sformatf("vector %0d dest or gr_we wrong", idx));
        assert (out_bus.res_from_mem == (vin.op_class == ex_pkg::cls_load)) else
            report_mismatch($sformatf("vector %0d res_from_mem wrong", idx));
        assert (dsram.wen == exp_wen[idx]) else
            report_mismatch($sformatf("vector %0d wen %b, expected %b",
                                      idx, dsram.wen, exp_wen[idx]));
        if (is_mem) begin
            assert (dsram.addr == exp_result[idx]) else
                report_mismatch($sformatf("vector %0d address %h, expected %h",
                                          idx, dsram.addr, exp_result[idx]));
        end
        if (vin.op_class == ex_pkg::cls_store) begin
            assert (dsram.wdata == exp_wdata[idx]) else
                report_mismatch($sformatf("vector %0d wdata %h, expected %h",
                                          idx, dsram.wdata, exp_wdata[idx]));
        end
    endtask

    initial begin : backpressure
        logic [31:0] rng;
        rng         = 32'hd5f4;
        out_allowin = 1'b0;
        forever begin
            @(posedge clk);
            rng = xorshift32(rng);
            // ready about three cycles in four
            out_allowin <= (rng[1:0] != 2'b00);
        end
    end

    initial begin : monitor
        ex_pkg::ex_out_t held_bus;
        logic            shown;
        int              latency;
        logic            is_div;
        held_bus   = '0;
        shown      = 1'b0;
        commit_idx = 0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                assert (dsram.wen == 4'b0000 || (out_valid && out_allowin)) else
                    report_mismatch("write strobe outside an output transfer");
                if (out_valid) begin
                    assert (commit_idx < num_vec) else
                        report_mismatch("out_valid with no instruction outstanding");
                    // a held result blocks new input unless it leaves now
                    assert (in_allowin == out_allowin) else
                        report_mismatch($sformatf("in_allowin %b with out_allowin %b",
                                                  in_allowin, out_allowin));
                    if (!shown) begin
                        latency = cycle - accept_cycle[commit_idx];
                        is_div  = (vec_in[commit_idx].op_class == ex_pkg::cls_div) ||
                                  (vec_in[commit_idx].op_class == ex_pkg::cls_divu);
                        if (is_div) begin
                            assert (latency == `EX_DIV_STEPS + 3) else
                                report_mismatch($sformatf("divide valid after %0d cycles",
                                                          latency));
                        end else begin
                            assert (latency == 1) else
                                report_mismatch($sformatf("vector %0d valid after %0d cycles",
                                                          commit_idx, latency));
                        end
                        held_bus = out_bus;
                        shown    = 1'b1;
                    end else begin
                        assert (out_bus == held_bus) else
                            report_mismatch("out_bus changed while held");
                    end
                    if (out_allowin) begin
                        check_commit(commit_idx);
                        commit_idx++;
                        shown = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : driver
        int i;
        int guard;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_bus   = '0;
        load_vectors();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!out_valid) else report_mismatch("out_valid high after reset");
        assert (dsram.wen == 4'b0000) else report_mismatch("wen nonzero after reset");
        assert (in_allowin) else report_mismatch("in_allowin low after reset");
        for (i = 0; i < num_vec; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_bus   <= vec_in[i];
            guard = 0;
            @(negedge clk);
            while (!in_allowin) begin
                guard++;
                if (guard > ACCEPT_TIMEOUT) begin
                    abort_run($sformatf("timeout: vector %0d was never accepted", i));
                end
                @(negedge clk);
            end
            accept_cycle[i] = cycle;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        guard = 0;
        while (commit_idx < num_vec) begin
            guard++;
            if (guard > DRAIN_TIMEOUT) begin
                abort_run("timeout: not every instruction left the stage");
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (!out_valid) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_mismatch("stage still valid after the last instruction left");
        end
    end

endmodule

// ==== sim/ex_vectors.txt ====
# cls op s1 s2 sz trap dest rs rt imm pc, then expected result ex_code wen wdata
# all hex, enum fields use the declaration order of ex_pkg
0 1 0 0 2 0 02 00000005 00000007 0000 00400000 0000000c 0 0 00000000
0 0 0 0 2 1 03 7fffffff 00000001 0000 00400004 80000000 1 0 00000000
0 0 0 0 2 0 03 7fffffff 00000001 0000 00400008 80000000 0 0 00000000
0 2 0 0 2 1 04 80000000 00000001 0000 0040000c 7fffffff 1 0 00000000
0 2 0 0 2 1 04 00000010 00000003 0000 00400010 0000000d 0 0 00000000
0 1 0 1 2 0 06 00001000 00000000 fff0 00400018 00000ff0 0 0 00000000
0 7 0 2 2 0 07 12340000 00000000 abcd 0040001c 1234abcd 0 0 00000000
0 1 2 3 2 0 1f 00000000 00000000 0000 00400020 00400028 0 0 00000000
0 a 1 0 2 0 08 00000000 0000000f 0100 00400024 000000f0 0 0 00000000
0 c 1 0 2 0 08 00000000 f0000000 0200 00400028 fff00000 0 0 00000000
0 b 1 0 2 0 08 00000000 f0000000 0200 0040002c 00f00000 0 0 00000000
0 4 0 0 2 0 09 ffffffff 00000001 0000 00400030 00000001 0 0 00000000
0 d 0 2 2 0 0a 00000000 00000000 1234 00400038 12340000 0 0 00000000
0 8 0 0 2 0 0b ff00ff00 0ff00ff0 0000 0040003c f0f0f0f0 0 0 00000000
0 9 0 0 2 0 0b 0000ffff 00ff0000 0000 00400040 ff000000 0 0 00000000
2 1 0 1 0 0 00 00001000 000000a5 0003 00400048 00001003 0 8 a5a5a5a5
2 1 0 1 0 0 00 00001000 0000003c 0001 0040004c 00001001 0 2 3c3c3c3c
2 1 0 1 1 0 00 00001000 0000beef 0002 00400050 00001002 0 c beefbeef
2 1 0 1 2 0 00 00001000 deadbeef 0004 00400058 00001004 0 f deadbeef
2 1 0 1 2 0 00 00001000 deadbeef 0006 0040005c 00001006 3 0 deadbeef
2 1 0 1 1 0 00 00001000 00001111 0001 00400060 00001001 3 0 11111111
2 0 0 1 2 1 00 7ffffffc 12345678 0008 00400064 80000004 1 0 12345678
1 1 0 1 2 0 0c 00001000 00000000 0008 00400068 00001008 0 0 00000000
1 1 0 1 2 0 0c 00001000 00000000 000a 0040006c 0000100a 2 0 00000000
1 1 0 1 1 0 0d 00001000 00000000 0003 00400070 00001003 2 0 00000000
3 1 0 0 2 0 00 fffffffe 00000003 0000 00400078 00000001 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 0040007c ffffffff 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 00400080 fffffffa 0 0 00000000
4 1 0 0 2 0 00 ffffffff 00000002 0000 00400084 00000001 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 00400088 00000001 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 0040008c fffffffe 0 0 00000000
9 1 0 0 2 0 00 11223344 00000000 0000 00400090 11223344 0 0 00000000
a 1 0 0 2 0 00 55667788 00000000 0000 00400094 55667788 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 00400098 11223344 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 0040009c 55667788 0 0 00000000
5 1 0 0 2 0 00 fffffff9 00000002 0000 004000a0 fffffffb 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 004000a4 ffffffff 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 004000a8 fffffffd 0 0 00000000
6 1 0 0 2 0 00 00000064 00000007 0000 004000ac 0000006b 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 004000b0 00000002 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 004000b4 0000000e 0 0 00000000
5 1 0 0 2 0 00 00000007 fffffffe 0000 004000b8 00000005 0 0 00000000
8 1 0 0 2 0 11 00000000 00000000 0000 004000bc fffffffd 0 0 00000000
7 1 0 0 2 0 10 00000000 00000000 0000 004000c0 00000001 0 0 00000000

// ==== ex_stage_top.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mem_access.sv
hdl/ex_divider.sv
hdl/ex_hilo.sv
hdl/ex_stage_ctrl.sv
hdl/ex_stage_top.sv
sim/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ex_stage
FILELIST  = ex_stage_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) > $(LOG) 2>&1; \
	./$(BUILD_DIR)/V$(TOP) >> $(LOG) 2>&1; \
	cat $(LOG); \
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
